/* verilog.f */
verilog/gr_heep_pkg.sv
verilog/reg_bus_if.sv
verilog/obi_periph_ctrl.sv
verilog/pad_control.sv
verilog/gpio_regs.sv
verilog/exit_regs.sv
verilog/pad_ring.sv
verilog/gr_heep_top.sv
dv/tb_gr_heep_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_gr_heep_top \
  -Mdir obj_dir \
  -f verilog.f

./obj_dir/Vtb_gr_heep_top | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi

echo "Simulation passed"

/* dv/tb_gr_heep_top.sv */
`timescale 1ns/1ps

module tb_gr_heep_top;
  import gr_heep_pkg::*;

  localparam int unsigned NumGpio = NumGpioDefault;
  localparam int Timeout = 50;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_i;
  logic      we_i;
  bus_be_t   be_i;
  bus_addr_t addr_i;
  bus_data_t wdata_i;
  logic      gnt_o;
  logic      rvalid_o;
  bus_data_t rdata_o;
  logic      gpio_0_i;
  logic      gpio_1_i;
  logic      gpio_3_i;
  logic      gpio_0_o;
  logic      gpio_0_oe_o;
  logic      gpio_1_o;
  logic      gpio_1_oe_o;
  logic      gpio_2_o;
  logic      gpio_4_o;
  logic      exit_valid_o;
  logic      exit_value_o;

  // Reference model state
  logic [NumGpio-1:0] out_m;
  logic [NumGpio-1:0] oe_m;
  logic [NumGpio-1:0] in_m;
  logic               mux2_m;
  logic               mux4_m;
  logic               exit_valid_m;
  bus_data_t          exit_val_m;

  // Expected responses, in grant order
  bus_data_t exp_q[$];
  bit        chk_q[$];
  bus_data_t head_data;
  bit        head_chk;
  bus_data_t last_rdata;

  logic        gnt_d;
  logic [31:0] lfsr = 32'hf6b3_b996;
  int          errors = 0;
  int          resp_cnt = 0;
  int          pin_cnt = 0;
  string       test_name = "init";

  gr_heep_top i_gr_heep_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .gpio_0_i    (gpio_0_i),
    .gpio_1_i    (gpio_1_i),
    .gpio_3_i    (gpio_3_i),
    .gpio_0_o    (gpio_0_o),
    .gpio_0_oe_o (gpio_0_oe_o),
    .gpio_1_o    (gpio_1_o),
    .gpio_1_oe_o (gpio_1_oe_o),
    .gpio_2_o    (gpio_2_o),
    .gpio_4_o    (gpio_4_o),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic bus_data_t lane_merge(bus_data_t old_val, bus_data_t new_val, bus_be_t be);
    bus_data_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  // Returns the expected rdata and applies a write to the model
  function automatic bus_data_t model_access(logic we, bus_addr_t addr, bus_be_t be,
                                             bus_data_t wdata);
    periph_sel_t sel;
    reg_offset_t off;
    bus_data_t   rd;
    bus_data_t   merged;
    sel = addr[15:12];
    off = addr[11:2];
    rd  = '0;
    case (sel)
      PeriphPadCtrl: begin
        if (off == PadMuxGpio2Off) begin
          rd[0] = mux2_m;
          if (we && be[0]) mux2_m = wdata[0];
        end else if (off == PadMuxGpio4Off) begin
          rd[0] = mux4_m;
          if (we && be[0]) mux4_m = wdata[0];
        end
      end
      PeriphGpio: begin
        if (off == GpioOutOff) begin
          rd     = bus_data_t'(out_m);
          merged = lane_merge(rd, wdata, be);
          if (we) out_m = merged[NumGpio-1:0];
        end else if (off == GpioOeOff) begin
          rd     = bus_data_t'(oe_m);
          merged = lane_merge(rd, wdata, be);
          if (we) oe_m = merged[NumGpio-1:0];
        end else if (off == GpioInOff) begin
          rd = bus_data_t'(in_m);
        end
      end
      PeriphExit: begin
        if (off == ExitValueOff) begin
          rd = exit_val_m;
          if (we) begin
            exit_val_m   = lane_merge(exit_val_m, wdata, be);
            exit_valid_m = 1'b1;
          end
        end
      end
      default: rd = '0;
    endcase
    // Writes always answer with zero
    return we ? '0 : rd;
  endfunction

  function automatic bus_addr_t make_addr(periph_sel_t sel, reg_offset_t off);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(16);
    lo = rand_bits(2);
    return {hi[15:0], sel, off, lo[1:0]};
  endfunction

  // ------------------------------------------------------------
  // Checkers
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    gnt_d <= gnt_o;
  end

  a_gnt_same_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_o == req_i)
    else begin
      errors++;
      $display("CHECK FAILED %s gnt_o expected %b actual %b",
               test_name, $sampled(req_i), $sampled(gnt_o));
    end

  a_rvalid_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                        rvalid_o == gnt_d)
    else begin
      errors++;
      $display("CHECK FAILED %s rvalid_o expected %b actual %b",
               test_name, $sampled(gnt_d), $sampled(rvalid_o));
    end

  // Compares each response against the oldest outstanding request
  always @(posedge clk_i) begin
    if (rst_n_i && rvalid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response arrived with no request outstanding in %s", test_name);
      end else begin
        head_data  = exp_q.pop_front();
        head_chk   = chk_q.pop_front();
        last_rdata = rdata_o;
        if (head_chk) begin
          resp_cnt++;
          a_rdata: assert (rdata_o === head_data) else begin
            errors++;
            $display("CHECK FAILED %s rdata_o expected %h actual %h",
                     test_name, head_data, rdata_o);
          end
        end
      end
    end
  end

  task automatic expect_bit(string what, logic exp, logic act);
    pin_cnt++;
    a_pin: assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_idle_outputs();
    expect_bit("gnt_o", 1'b0, gnt_o);
    expect_bit("rvalid_o", 1'b0, rvalid_o);
    expect_bit("exit_valid_o", 1'b0, exit_valid_o);
    expect_bit("gpio_0_oe_o", 1'b0, gpio_0_oe_o);
    expect_bit("gpio_1_oe_o", 1'b0, gpio_1_oe_o);
  endtask

  task automatic check_pins();
    expect_bit("gpio_0_o", out_m[0], gpio_0_o);
    expect_bit("gpio_0_oe_o", oe_m[0], gpio_0_oe_o);
    expect_bit("gpio_1_o", out_m[1], gpio_1_o);
    expect_bit("gpio_1_oe_o", oe_m[1], gpio_1_oe_o);
    expect_bit("gpio_2_o", mux2_m ? exit_valid_m : out_m[2], gpio_2_o);
    expect_bit("gpio_4_o", mux4_m ? exit_val_m[0] : out_m[4], gpio_4_o);
    expect_bit("exit_valid_o", exit_valid_m, exit_valid_o);
    expect_bit("exit_value_o", exit_val_m[0], exit_value_o);
  endtask

  task automatic abort_run(string what);
    $display("Timeout in %s: %s", test_name, what);
    $display("Errors found");
    $finish;
  endtask

  // ------------------------------------------------------------
  // Bus driver, called right after a rising edge
  // ------------------------------------------------------------
  task automatic bus_req(input logic we, input bus_addr_t addr, input bus_be_t be,
                         input bus_data_t wdata, input bit check);
    bit        granted;
    bus_data_t exp;
    granted = 1'b0;
    req_i   <= 1'b1;
    we_i    <= we;
    be_i    <= be;
    addr_i  <= addr;
    wdata_i <= wdata;
    for (int n = 0; n < Timeout; n++) begin
      @(posedge clk_i);
      if (gnt_o) begin
        granted = 1'b1;
        break;
      end
    end
    if (!granted) begin
      abort_run("request never granted");
    end else begin
      exp = model_access(we, addr, be, wdata);
      exp_q.push_back(exp);
      chk_q.push_back(check);
    end
  endtask

  task automatic write_reg(periph_sel_t sel, reg_offset_t off, bus_be_t be, bus_data_t data);
    bus_req(1'b1, make_addr(sel, off), be, data, 1'b1);
  endtask

  task automatic read_reg(periph_sel_t sel, reg_offset_t off);
    bus_req(1'b0, make_addr(sel, off), 4'hf, '0, 1'b1);
  endtask

  // Waits for all responses, returns on a rising edge
  task automatic drain();
    bit empty;
    empty = 1'b0;
    req_i <= 1'b0;
    for (int n = 0; n < Timeout; n++) begin
      @(negedge clk_i);
      if (exp_q.size() == 0) begin
        empty = 1'b1;
        break;
      end
    end
    if (!empty) begin
      abort_run("responses still outstanding");
    end else begin
      @(posedge clk_i);
    end
  endtask

  task automatic read_all_regs();
    read_reg(PeriphPadCtrl, PadMuxGpio2Off);
    read_reg(PeriphPadCtrl, PadMuxGpio4Off);
    read_reg(PeriphGpio, GpioOutOff);
    read_reg(PeriphGpio, GpioOeOff);
    read_reg(PeriphGpio, GpioInOff);
    read_reg(PeriphExit, ExitValueOff);
  endtask

  // ------------------------------------------------------------
  // Test sequences
  // ------------------------------------------------------------
  task automatic reset_and_check();
    test_name    = "reset";
    out_m        = '0;
    oe_m         = '0;
    in_m         = '0;
    mux2_m       = 1'b0;
    mux4_m       = 1'b0;
    exit_valid_m = 1'b0;
    exit_val_m   = '0;
    @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    rst_n_i <= 1'b1;
    req_i   <= 1'b0;
    @(posedge clk_i);
    check_idle_outputs();
    read_all_regs();
    drain();
  endtask

  task automatic run_gpio_out();
    logic [31:0] be;
    test_name = "gpio_out_oe";
    for (int i = 0; i < 8; i++) begin
      be = rand_bits(4);
      write_reg(PeriphGpio, GpioOutOff, be[3:0], rand_bits(32));
      be = rand_bits(4);
      write_reg(PeriphGpio, GpioOeOff, be[3:0], rand_bits(32));
      read_reg(PeriphGpio, GpioOutOff);
      read_reg(PeriphGpio, GpioOeOff);
      drain();
      check_pins();
    end
  endtask

  task automatic run_gpio_in();
    logic [31:0]        pins;
    logic [NumGpio-1:0] want_in;
    bit                 matched;
    test_name = "gpio_in";
    for (int k = 0; k < 4; k++) begin
      pins       = rand_bits(3);
      gpio_0_i  <= pins[0];
      gpio_1_i  <= pins[1];
      gpio_3_i  <= pins[2];
      want_in    = '0;
      want_in[0] = pins[0];
      want_in[1] = pins[1];
      want_in[3] = pins[2];
      matched    = 1'b0;
      // Poll until the synchronizer has caught up
      for (int n = 0; n < Timeout; n++) begin
        bus_req(1'b0, make_addr(PeriphGpio, GpioInOff), 4'hf, '0, 1'b0);
        drain();
        if (last_rdata == bus_data_t'(want_in)) begin
          matched = 1'b1;
          break;
        end
      end
      if (!matched) begin
        abort_run("GPIO IN never matched the pin levels");
      end else begin
        in_m = want_in;
        read_reg(PeriphGpio, GpioInOff);
        drain();
      end
    end
  endtask

  task automatic run_exit_and_mux();
    logic [31:0] be;
    test_name = "exit";
    be = rand_bits(4);
    write_reg(PeriphExit, ExitValueOff, be[3:0], rand_bits(32));
    read_reg(PeriphExit, ExitValueOff);
    drain();
    expect_bit("exit_valid_o", 1'b1, exit_valid_o);
    check_pins();

    test_name = "pad_mux_on";
    // OUT bits 2 and 4 set opposite to the alternate pin functions
    write_reg(PeriphGpio, GpioOutOff, 4'h1, bus_data_t'({~exit_val_m[0], 4'b0000}));
    write_reg(PeriphPadCtrl, PadMuxGpio2Off, 4'h1, 32'h1);
    write_reg(PeriphPadCtrl, PadMuxGpio4Off, 4'h1, 32'h1);
    read_reg(PeriphPadCtrl, PadMuxGpio2Off);
    read_reg(PeriphPadCtrl, PadMuxGpio4Off);
    drain();
    check_pins();

    test_name = "pad_mux_off";
    write_reg(PeriphPadCtrl, PadMuxGpio2Off, 4'h1, 32'h0);
    write_reg(PeriphPadCtrl, PadMuxGpio4Off, 4'h1, 32'h0);
    drain();
    check_pins();
  endtask

  // Back-to-back traffic, many requests hit unmapped indices
  task automatic run_random_mix();
    logic [31:0] r;
    logic [31:0] d;
    periph_sel_t sel;
    reg_offset_t off;
    test_name = "random_mix";
    for (int i = 0; i < 60; i++) begin
      r = rand_bits(1);
      if (r[0]) begin
        r   = rand_bits(2);
        sel = periph_sel_t'(r[1:0]);
      end else begin
        r   = rand_bits(4);
        sel = r[3:0];
      end
      r   = rand_bits(2);
      off = reg_offset_t'(r[1:0]);
      r   = rand_bits(5);
      d   = rand_bits(32);
      bus_req(r[0], make_addr(sel, off), r[4:1], d, 1'b1);
    end
    drain();
    test_name = "random_mix_final";
    read_all_regs();
    drain();
    check_pins();
  endtask

  initial begin
    rst_n_i  <= 1'b0;
    // Request held during reset, it must not be granted
    req_i    <= 1'b1;
    we_i     <= 1'b0;
    be_i     <= '0;
    addr_i   <= '0;
    wdata_i  <= '0;
    gpio_0_i <= 1'b0;
    gpio_1_i <= 1'b0;
    gpio_3_i <= 1'b0;

    reset_and_check();
    run_gpio_out();
    run_gpio_in();
    run_exit_and_mux();
    run_random_mix();

    $display("Summary: %0d responses checked, %0d pin checks, %0d failures",
             resp_cnt, pin_cnt, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verilog/gr_heep_top.sv */
`timescale 1ns/1ps

module gr_heep_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // OBI slave port for the external bridge
  input  logic                   req_i,
  input  logic                   we_i,
  input  gr_heep_pkg::bus_be_t   be_i,
  input  gr_heep_pkg::bus_addr_t addr_i,
  input  gr_heep_pkg::bus_data_t wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output gr_heep_pkg::bus_data_t rdata_o,

  // Pins
  input  logic                   gpio_0_i,
  input  logic                   gpio_1_i,
  input  logic                   gpio_3_i,
  output logic                   gpio_0_o,
  output logic                   gpio_0_oe_o,
  output logic                   gpio_1_o,
  output logic                   gpio_1_oe_o,
  output logic                   gpio_2_o,
  output logic                   gpio_4_o,
  output logic                   exit_valid_o,
  output logic                   exit_value_o
);
  import gr_heep_pkg::*;

  localparam int unsigned NumGpio = NumGpioDefault;

  reg_bus_if pad_bus ();
  reg_bus_if gpio_bus ();
  reg_bus_if exit_bus ();

  pad_mux_t           pad_mux_gpio2;
  pad_mux_t           pad_mux_gpio4;
  logic [NumGpio-1:0] gpio_out;
  logic [NumGpio-1:0] gpio_oe;
  logic [NumGpio-1:0] gpio_in;
  bus_data_t          exit_value;
  logic               exit_valid;

  // ------------------------------------------------------------
  // Bus controller
  // ------------------------------------------------------------
  obi_periph_ctrl u_obi_periph_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .we_i      (we_i),
    .be_i      (be_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .gnt_o     (gnt_o),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .pad_bus_o (pad_bus.host),
    .gpio_bus_o(gpio_bus.host),
    .exit_bus_o(exit_bus.host)
  );

  // ------------------------------------------------------------
  // Peripherals
  // ------------------------------------------------------------
  pad_control u_pad_control (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .reg_bus_i      (pad_bus.device),
    .pad_mux_gpio2_o(pad_mux_gpio2),
    .pad_mux_gpio4_o(pad_mux_gpio4)
  );

  gpio_regs #(
    .NumGpio(NumGpio)
  ) u_gpio_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .reg_bus_i (gpio_bus.device),
    .gpio_in_i (gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_oe_o (gpio_oe)
  );

  exit_regs u_exit_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_bus_i   (exit_bus.device),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid)
  );

  // Pad ring
  pad_ring #(
    .NumGpio(NumGpio)
  ) u_pad_ring (
    .gpio_out_i     (gpio_out),
    .gpio_oe_i      (gpio_oe),
    .gpio_in_o      (gpio_in),
    .pad_mux_gpio2_i(pad_mux_gpio2),
    .pad_mux_gpio4_i(pad_mux_gpio4),
    .exit_valid_i   (exit_valid),
    .exit_value_i   (exit_value),
    .gpio_0_i       (gpio_0_i),
    .gpio_1_i       (gpio_1_i),
    .gpio_3_i       (gpio_3_i),
    .gpio_0_o       (gpio_0_o),
    .gpio_0_oe_o    (gpio_0_oe_o),
    .gpio_1_o       (gpio_1_o),
    .gpio_1_oe_o    (gpio_1_oe_o),
    .gpio_2_o       (gpio_2_o),
    .gpio_4_o       (gpio_4_o),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

endmodule

/* verilog/pad_ring.sv */
`timescale 1ns/1ps

module pad_ring #(
  parameter int unsigned NumGpio = gr_heep_pkg::NumGpioDefault
) (
  // Core side
  input  logic [NumGpio-1:0]      gpio_out_i,
  input  logic [NumGpio-1:0]      gpio_oe_i,
  output logic [NumGpio-1:0]      gpio_in_o,
  input  gr_heep_pkg::pad_mux_t   pad_mux_gpio2_i,
  input  gr_heep_pkg::pad_mux_t   pad_mux_gpio4_i,
  input  logic                    exit_valid_i,
  input  gr_heep_pkg::bus_data_t  exit_value_i,

  // Pin side
  input  logic                    gpio_0_i,
  input  logic                    gpio_1_i,
  input  logic                    gpio_3_i,
  output logic                    gpio_0_o,
  output logic                    gpio_0_oe_o,
  output logic                    gpio_1_o,
  output logic                    gpio_1_oe_o,
  output logic                    gpio_2_o,
  output logic                    gpio_4_o,
  output logic                    exit_valid_o,
  output logic                    exit_value_o
);

  // Only pins 0, 1 and 3 can be read back
  always_comb begin
    gpio_in_o    = '0;
    gpio_in_o[0] = gpio_0_i;
    gpio_in_o[1] = gpio_1_i;
    gpio_in_o[3] = gpio_3_i;
  end

  // Bidirectional pins
  assign gpio_0_o    = gpio_out_i[0];
  assign gpio_0_oe_o = gpio_oe_i[0];
  assign gpio_1_o    = gpio_out_i[1];
  assign gpio_1_oe_o = gpio_oe_i[1];

  // Shared output pins
  assign gpio_2_o = pad_mux_gpio2_i ? exit_valid_i : gpio_out_i[2];
  assign gpio_4_o = pad_mux_gpio4_i ? exit_value_i[0] : gpio_out_i[4];

  assign exit_valid_o = exit_valid_i;
  assign exit_value_o = exit_value_i[0];

endmodule

/* verilog/exit_regs.sv */
`timescale 1ns/1ps

module exit_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  reg_bus_if.device              reg_bus_i,
  output gr_heep_pkg::bus_data_t exit_value_o,
  output logic                   exit_valid_o
);
  import gr_heep_pkg::*;

  bus_data_t value_q;
  logic      valid_q;

  // Any write to the value marks the exit, the flag is sticky
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      value_q <= '0;
      valid_q <= 1'b0;
    end else if (reg_bus_i.valid && reg_bus_i.write && (reg_bus_i.addr == ExitValueOff)) begin
      value_q <= be_merge(value_q, reg_bus_i.wdata, reg_bus_i.wstrb);
      valid_q <= 1'b1;
    end
  end

  assign reg_bus_i.rdata = (reg_bus_i.addr == ExitValueOff) ? value_q : '0;

  assign exit_value_o = value_q;
  assign exit_valid_o = valid_q;

  a_exit_valid_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_o |=> exit_valid_o
  );

endmodule

/* verilog/gpio_regs.sv */
`timescale 1ns/1ps

module gpio_regs #(
  parameter int unsigned NumGpio = gr_heep_pkg::NumGpioDefault
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  reg_bus_if.device          reg_bus_i,
  input  logic [NumGpio-1:0] gpio_in_i,
  output logic [NumGpio-1:0] gpio_out_o,
  output logic [NumGpio-1:0] gpio_oe_o
);
  import gr_heep_pkg::*;

  logic [NumGpio-1:0] out_q;
  logic [NumGpio-1:0] oe_q;
  logic [NumGpio-1:0] in_meta_q;
  logic [NumGpio-1:0] in_sync_q;

  // Zero-extended register views
  bus_data_t out_word;
  bus_data_t oe_word;
  bus_data_t in_word;
  bus_data_t out_merged;
  bus_data_t oe_merged;

  assign out_word = bus_data_t'(out_q);
  assign oe_word  = bus_data_t'(oe_q);
  assign in_word  = bus_data_t'(in_sync_q);

  assign out_merged = be_merge(out_word, reg_bus_i.wdata, reg_bus_i.wstrb);
  assign oe_merged  = be_merge(oe_word, reg_bus_i.wdata, reg_bus_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oe_q  <= '0;
    end else if (reg_bus_i.valid && reg_bus_i.write) begin
      case (reg_bus_i.addr)
        GpioOutOff: out_q <= out_merged[NumGpio-1:0];
        GpioOeOff:  oe_q  <= oe_merged[NumGpio-1:0];
        default: ;  // IN is read-only
      endcase
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_in_i;
      in_sync_q <= in_meta_q;
    end
  end

  always_comb begin
    case (reg_bus_i.addr)
      GpioOutOff: reg_bus_i.rdata = out_word;
      GpioOeOff:  reg_bus_i.rdata = oe_word;
      GpioInOff:  reg_bus_i.rdata = in_word;
      default:    reg_bus_i.rdata = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;

  a_upper_bits_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (reg_bus_i.rdata >> NumGpio) == '0
  );

endmodule

/* verilog/pad_control.sv */
`timescale 1ns/1ps

module pad_control (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  reg_bus_if.device             reg_bus_i,
  output gr_heep_pkg::pad_mux_t pad_mux_gpio2_o,
  output gr_heep_pkg::pad_mux_t pad_mux_gpio4_o
);
  import gr_heep_pkg::*;

  pad_mux_t mux_gpio2_q;
  pad_mux_t mux_gpio4_q;

  // Select bits live in bit 0, only byte lane 0 matters
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mux_gpio2_q <= 1'b0;
      mux_gpio4_q <= 1'b0;
    end else if (reg_bus_i.valid && reg_bus_i.write && reg_bus_i.wstrb[0]) begin
      case (reg_bus_i.addr)
        PadMuxGpio2Off: mux_gpio2_q <= reg_bus_i.wdata[0];
        PadMuxGpio4Off: mux_gpio4_q <= reg_bus_i.wdata[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_bus_i.rdata = '0;
    case (reg_bus_i.addr)
      PadMuxGpio2Off: reg_bus_i.rdata[0] = mux_gpio2_q;
      PadMuxGpio4Off: reg_bus_i.rdata[0] = mux_gpio4_q;
      default: ;
    endcase
  end

  assign pad_mux_gpio2_o = mux_gpio2_q;
  assign pad_mux_gpio4_o = mux_gpio4_q;

  // Offset comes from the OBI address through the controller
  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    reg_bus_i.valid |-> !$isunknown(reg_bus_i.addr)
  );

endmodule

/* verilog/obi_periph_ctrl.sv */
`timescale 1ns/1ps

module obi_periph_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // OBI request
  input  logic                  req_i,
  input  logic                  we_i,
  input  gr_heep_pkg::bus_be_t   be_i,
  input  gr_heep_pkg::bus_addr_t addr_i,
  input  gr_heep_pkg::bus_data_t wdata_i,

  // OBI response
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output gr_heep_pkg::bus_data_t rdata_o,

  // Register buses to the peripherals
  reg_bus_if.host               pad_bus_o,
  reg_bus_if.host               gpio_bus_o,
  reg_bus_if.host               exit_bus_o
);
  import gr_heep_pkg::*;

  periph_sel_t sel;
  reg_offset_t offset;
  logic        gnt;
  bus_data_t   rdata_mux;
  logic        rvalid_q;
  bus_data_t   rdata_q;

  // ------------------------------------------------------------
  // Request side
  // ------------------------------------------------------------
  assign sel    = addr_i[PeriphSelLsb+:$bits(periph_sel_t)];
  assign offset = addr_i[RegOffsetLsb+:$bits(reg_offset_t)];

  // No back-pressure, every request is taken in its own cycle
  assign gnt   = req_i & rst_n_i;
  assign gnt_o = gnt;

  assign pad_bus_o.valid  = gnt && (sel == PeriphPadCtrl);
  assign pad_bus_o.write  = we_i;
  assign pad_bus_o.wstrb  = be_i;
  assign pad_bus_o.addr   = offset;
  assign pad_bus_o.wdata  = wdata_i;

  assign gpio_bus_o.valid = gnt && (sel == PeriphGpio);
  assign gpio_bus_o.write = we_i;
  assign gpio_bus_o.wstrb = be_i;
  assign gpio_bus_o.addr  = offset;
  assign gpio_bus_o.wdata = wdata_i;

  assign exit_bus_o.valid = gnt && (sel == PeriphExit);
  assign exit_bus_o.write = we_i;
  assign exit_bus_o.wstrb = be_i;
  assign exit_bus_o.addr  = offset;
  assign exit_bus_o.wdata = wdata_i;

  // Read data demux, writes and holes return zero
  always_comb begin
    case (sel)
      PeriphPadCtrl: rdata_mux = pad_bus_o.rdata;
      PeriphGpio:    rdata_mux = gpio_bus_o.rdata;
      PeriphExit:    rdata_mux = exit_bus_o.rdata;
      default:       rdata_mux = '0;
    endcase
    if (we_i) begin
      rdata_mux = '0;
    end
  end

  // ------------------------------------------------------------
  // Response stage
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt;
      // Sampled before the peripheral applies a write at this edge
      if (gnt) begin
        rdata_q <= rdata_mux;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Every grant gets exactly one response, on the next cycle
  a_rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o == $past(gnt_o)
  );

endmodule

/* verilog/reg_bus_if.sv */
`timescale 1ns/1ps

interface reg_bus_if;
  import gr_heep_pkg::*;

  // Strobe-style register access, one word per cycle
  logic        valid;
  logic        write;
  bus_be_t     wstrb;
  reg_offset_t addr;
  bus_data_t   wdata;
  // Combinational read of the addressed register
  bus_data_t   rdata;

  modport host (
    output valid,
    output write,
    output wstrb,
    output addr,
    output wdata,
    input  rdata
  );

  modport device (
    input  valid,
    input  write,
    input  wstrb,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

/* verilog/gr_heep_pkg.sv */
package gr_heep_pkg;

  // Bus widths
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;

  // Address fields
  typedef logic [3:0] periph_sel_t;
  typedef logic [9:0] reg_offset_t;
  localparam int unsigned PeriphSelLsb = 12;
  localparam int unsigned RegOffsetLsb = 2;

  // 0 keeps the GPIO function, 1 picks the alternate one
  typedef logic pad_mux_t;

  // ------------------------------------------------------------
  // Peripheral map and register offsets
  // ------------------------------------------------------------
  localparam periph_sel_t PeriphPadCtrl = 4'd0;
  localparam periph_sel_t PeriphGpio    = 4'd1;
  localparam periph_sel_t PeriphExit    = 4'd2;

  localparam reg_offset_t PadMuxGpio2Off = 10'd0;
  localparam reg_offset_t PadMuxGpio4Off = 10'd1;

  localparam reg_offset_t GpioOutOff = 10'd0;
  localparam reg_offset_t GpioOeOff  = 10'd1;
  localparam reg_offset_t GpioInOff  = 10'd2;

  localparam reg_offset_t ExitValueOff = 10'd0;

  localparam int unsigned NumGpioDefault = 5;

  // Byte-lane merge of a write into a register word
  function automatic bus_data_t be_merge(bus_data_t old_val, bus_data_t new_val, bus_be_t be);
    bus_data_t res;
    res = old_val;
    for (int i = 0; i < $bits(bus_be_t); i++) begin
      if (be[i]) begin
        res[8*i+:8] = new_val[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage
